//--- hw/isa_pkg.sv
package isa_pkg;

    // major opcode and field positions of a 32-bit instruction
    localparam int OPC_W   = 7;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int CSR_LSB = 20;

    localparam logic [OPC_W-1:0] OPC_SYSTEM = 7'b1110011;

    localparam int REG_ADDR_W = 5;

    // funct3 codes of the zicsr instructions
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // values follow funct3[1:0]
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

endpackage

//--- hw/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // free-running counter, read as cycle / cycleh
    localparam int CYCLE_W = 64;

    // machine-mode CSRs
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // user-level counters, read only
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE    = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH   = 12'hC80;

endpackage

//--- hw/csr_if.sv
`timescale 1ns/100ps

interface csr_if import csr_pkg::*; ();

    logic                  wen;    // write strobe from ex
    logic [CSR_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic [CSR_ADDR_W-1:0] raddr;  // read address from id
    logic [XLEN-1:0]       rdata;

    modport decode (
        output raddr,
        input  rdata
    );

    modport alu (
        output wen, waddr, wdata
    );

    modport regfile (
        input  wen, waddr, wdata, raddr,
        output rdata
    );

endinterface

//--- hw/csr_decode.sv
`timescale 1ns/100ps

module csr_decode import csr_pkg::*, isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    csr_if.decode                 csr,
    output logic                  ex_valid_o,
    output csr_op_e               ex_op_o,
    output logic [CSR_ADDR_W-1:0] ex_addr_o,
    output logic [XLEN-1:0]       ex_operand_o,
    output logic [XLEN-1:0]       ex_old_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_wr_en_o
);

    logic [2:0]            f3;
    logic [REG_ADDR_W-1:0] rs1_fld;
    logic                  is_csr;

    logic                  id_valid;
    logic [2:0]            id_f3;
    logic [CSR_ADDR_W-1:0] id_addr;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [XLEN-1:0]       id_operand;
    csr_op_e               id_op;
    logic                  id_wr_en;

    assign f3      = instr_i[F3_LSB +: 3];
    assign rs1_fld = instr_i[RS1_LSB +: REG_ADDR_W];
    // funct3 100 is not a csr op either
    assign is_csr  = (instr_i[OPC_W-1:0] == OPC_SYSTEM) && (f3[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= instr_valid_i && is_csr;
        end
    end

    always_ff @(posedge clk) begin
        id_f3   <= f3;
        id_addr <= instr_i[CSR_LSB +: CSR_ADDR_W];
        id_rd   <= instr_i[RD_LSB +: REG_ADDR_W];
        id_rs1  <= rs1_fld;
        // immediate forms take zimm zero-extended
        id_operand <= f3[2] ? {{(XLEN-REG_ADDR_W){1'b0}}, rs1_fld} : rs1_data_i;
    end

    assign csr.raddr = id_addr;

    always_comb begin
        case (id_f3)
            F3_CSRRW, F3_CSRRWI: id_op = CSR_OP_WRITE;
            F3_CSRRS, F3_CSRRSI: id_op = CSR_OP_SET;
            F3_CSRRC, F3_CSRRCI: id_op = CSR_OP_CLEAR;
            default:             id_op = CSR_OP_WRITE;
        endcase
    end

    // set/clear with x0 or zimm 0 only read
    assign id_wr_en = (id_op == CSR_OP_WRITE) || (id_rs1 != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_o      <= id_op;
        ex_addr_o    <= id_addr;
        ex_operand_o <= id_operand;
        ex_old_o     <= csr.rdata;  // already forwarded by the regfile
        ex_rd_o      <= id_rd;
        ex_wr_en_o   <= id_wr_en;
    end

endmodule

//--- hw/csr_alu.sv
`timescale 1ns/100ps

module csr_alu import csr_pkg::*, isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ex_valid_i,
    input  csr_op_e               ex_op_i,
    input  logic [CSR_ADDR_W-1:0] ex_addr_i,
    input  logic [XLEN-1:0]       ex_operand_i,
    input  logic [XLEN-1:0]       ex_old_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_wr_en_i,
    csr_if.alu                    csr,
    output logic                  rd_valid_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_data_o
);

    logic [XLEN-1:0] new_val;

    always_comb begin
        case (ex_op_i)
            CSR_OP_SET:   new_val = ex_old_i | ex_operand_i;
            CSR_OP_CLEAR: new_val = ex_old_i & ~ex_operand_i;
            default:      new_val = ex_operand_i;  // plain write
        endcase
    end

    // write lands at the edge ending the ex cycle
    assign csr.wen   = ex_valid_i && ex_wr_en_i;
    assign csr.waddr = ex_addr_i;
    assign csr.wdata = new_val;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= ex_valid_i;
        end
    end

    // rd gets the value before the update
    always_ff @(posedge clk) begin
        rd_addr_o <= ex_rd_i;
        rd_data_o <= ex_old_i;
    end

endmodule

//--- hw/csr_reg.sv
`timescale 1ns/100ps

module csr_reg import csr_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    csr_if.regfile          csr,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [CYCLE_W-1:0] cycle;
    logic [XLEN-1:0]    mtvec;
    logic [XLEN-1:0]    mcause;
    logic [XLEN-1:0]    mepc;
    logic [XLEN-1:0]    mie;
    logic [XLEN-1:0]    mstatus;
    logic [XLEN-1:0]    mscratch;

    logic               waddr_ok;  // waddr is one of the writable CSRs
    logic               fwd;

    // counts from the end of reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    always_comb begin
        case (csr.waddr)
            CSR_MSTATUS, CSR_MIE, CSR_MTVEC,
            CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE: waddr_ok = 1'b1;
            default:                            waddr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mtvec    <= '0;
            mcause   <= '0;
            mepc     <= '0;
            mie      <= '0;
            mstatus  <= '0;
            mscratch <= '0;
        end else if (csr.wen) begin
            case (csr.waddr)
                CSR_MTVEC:    mtvec    <= csr.wdata;
                CSR_MCAUSE:   mcause   <= csr.wdata;
                CSR_MEPC:     mepc     <= csr.wdata;
                CSR_MIE:      mie      <= csr.wdata;
                CSR_MSTATUS:  mstatus  <= csr.wdata;
                CSR_MSCRATCH: mscratch <= csr.wdata;
                default: ;                           // cycle, cycleh and unknown dropped
            endcase
        end
    end

    // only a write that will actually land may be forwarded
    assign fwd = csr.wen && waddr_ok && (csr.waddr == csr.raddr);

    always_comb begin
        if (fwd) begin
            csr.rdata = csr.wdata;
        end else begin
            case (csr.raddr)
                CSR_CYCLE:    csr.rdata = cycle[XLEN-1:0];
                CSR_CYCLEH:   csr.rdata = cycle[CYCLE_W-1:XLEN];
                CSR_MTVEC:    csr.rdata = mtvec;
                CSR_MCAUSE:   csr.rdata = mcause;
                CSR_MEPC:     csr.rdata = mepc;
                CSR_MIE:      csr.rdata = mie;
                CSR_MSTATUS:  csr.rdata = mstatus;
                CSR_MSCRATCH: csr.rdata = mscratch;
                default:      csr.rdata = '0;
            endcase
        end
    end

    // trap vector and return address for fetch
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/100ps

module csr_unit import csr_pkg::*, isa_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] rs1_data_i,
    output logic            rd_valid_o,
    output logic [4:0]      rd_addr_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    // id -> ex stage registers
    logic                  ex_valid;
    csr_op_e               ex_op;
    logic [CSR_ADDR_W-1:0] ex_addr;
    logic [XLEN-1:0]       ex_operand;
    logic [XLEN-1:0]       ex_old;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_wr_en;

    csr_if csr_bus ();

    csr_decode u_decode (
        .clk          (clk),
        .rstn         (rstn),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .rs1_data_i   (rs1_data_i),
        .csr          (csr_bus.decode),
        .ex_valid_o   (ex_valid),
        .ex_op_o      (ex_op),
        .ex_addr_o    (ex_addr),
        .ex_operand_o (ex_operand),
        .ex_old_o     (ex_old),
        .ex_rd_o      (ex_rd),
        .ex_wr_en_o   (ex_wr_en)
    );

    csr_alu u_alu (
        .clk         (clk),
        .rstn        (rstn),
        .ex_valid_i  (ex_valid),
        .ex_op_i     (ex_op),
        .ex_addr_i   (ex_addr),
        .ex_operand_i(ex_operand),
        .ex_old_i    (ex_old),
        .ex_rd_i     (ex_rd),
        .ex_wr_en_i  (ex_wr_en),
        .csr         (csr_bus.alu),
        .rd_valid_o  (rd_valid_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o)
    );

    csr_reg u_reg (
        .clk    (clk),
        .rstn   (rstn),
        .csr    (csr_bus.regfile),
        .mtvec_o(mtvec_o),
        .mepc_o (mepc_o)
    );

endmodule

//--- testbench/csr_unit_sva.sv
`timescale 1ns/100ps

module csr_unit_sva import csr_pkg::*, isa_pkg::*; (
    input logic            clk,
    input logic            rstn,
    input logic            instr_valid_i,
    input logic [31:0]     instr_i,
    input logic [XLEN-1:0] rs1_data_i,
    input logic            rd_valid_o,
    input logic [4:0]      rd_addr_o,
    input logic [XLEN-1:0] rd_data_o,
    input logic [XLEN-1:0] mtvec_o,
    input logic [XLEN-1:0] mepc_o
);

    typedef struct packed {
        logic            valid;
        logic [31:0]     ins;
        logic [XLEN-1:0] data;
        logic [31:0]     tick;
    } slot_t;

    int              fail_cnt = 0;
    slot_t           p [3];      // each instruction one, two and three cycles after issue
    logic [XLEN-1:0] sh [4096];  // shadow CSRs by address; cycle, cycleh and unmapped stay zero
    logic [31:0]     tick;
    logic [XLEN-1:0] old_val;    // value the instruction in p[2] must return
    logic [XLEN-1:0] opnd;
    logic [XLEN-1:0] cyc_val;
    logic [31:0]     cyc_tick;
    logic            cyc_seen;
    logic            csr_in;

    // funct3 000 and 100 are not csr ops
    assign csr_in = instr_valid_i && instr_i[6:0] == OPC_SYSTEM && instr_i[13:12] != 2'b00;
    assign opnd   = p[1].ins[14] ? XLEN'(p[1].ins[19:15]) : p[1].data;  // zimm or rs1 data

    task automatic count_failure(input string msg);
        fail_cnt++;
        $error("Error %0t: %s", $time, msg);
    endtask

    always_ff @(posedge clk) begin
        if (!rstn) begin
            p        <= '{default: '0};
            sh       <= '{default: '0};
            tick     <= '0;
            cyc_seen <= 1'b0;
        end else begin
            tick    <= tick + 32'd1;
            p[0]    <= '{csr_in, instr_i, rs1_data_i, tick};
            p[1]    <= p[0];
            p[2]    <= p[1];
            old_val <= sh[p[1].ins[31:20]];
            // set and clear with a zero rs1 field only read
            if (p[1].valid && (p[1].ins[13:12] == 2'b01 || p[1].ins[19:15] != '0) &&
                p[1].ins[31:20] inside {CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                        CSR_MEPC, CSR_MCAUSE}) begin
                case (p[1].ins[13:12])
                    2'b01:   sh[p[1].ins[31:20]] <= opnd;
                    2'b10:   sh[p[1].ins[31:20]] <= sh[p[1].ins[31:20]] | opnd;
                    default: sh[p[1].ins[31:20]] <= sh[p[1].ins[31:20]] & ~opnd;
                endcase
            end
            if (p[2].valid && p[2].ins[31:20] == CSR_CYCLE) begin
                cyc_seen <= 1'b1;
                cyc_val  <= rd_data_o;
                cyc_tick <= p[2].tick;
            end
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (!rstn) csr_in |-> ##3 rd_valid_o)
        else count_failure("no rd result 3 cycles after a csr instruction");
    a_no_extra: assert property (@(posedge clk) disable iff (!rstn) rd_valid_o |-> p[2].valid)
        else count_failure("rd result without a csr instruction 3 cycles before");
    a_rd_addr: assert property (@(posedge clk) disable iff (!rstn)
        p[2].valid |-> rd_addr_o == p[2].ins[11:7])
        else count_failure("rd_addr_o differs from the rd field");
    a_rd_data: assert property (@(posedge clk) disable iff (!rstn)
        p[2].valid && p[2].ins[31:20] != CSR_CYCLE |-> rd_data_o == old_val)
        else count_failure("rd_data_o differs from the shadow CSR value");
    a_cycle: assert property (@(posedge clk) disable iff (!rstn)
        p[2].valid && p[2].ins[31:20] == CSR_CYCLE && cyc_seen |->
        rd_data_o - cyc_val == p[2].tick - cyc_tick)
        else count_failure("cycle reads differ by other than their issue distance");
    a_fetch: assert property (@(posedge clk) disable iff (!rstn)
        mtvec_o == sh[CSR_MTVEC] && mepc_o == sh[CSR_MEPC])
        else count_failure("mtvec_o or mepc_o differs from the shadow");

endmodule

//--- testbench/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb import csr_pkg::*, isa_pkg::*; ();

    logic            clk;
    logic            rstn;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] rs1_data_i;
    logic            rd_valid_o;
    logic [4:0]      rd_addr_o;
    logic [XLEN-1:0] rd_data_o;
    logic [XLEN-1:0] mtvec_o;
    logic [XLEN-1:0] mepc_o;

    logic [31:0]           lfsr = 32'h87d77461;
    logic [CSR_ADDR_W-1:0] addr_tab [9] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
        CSR_MEPC, CSR_MCAUSE, CSR_CYCLE, CSR_CYCLEH, 12'h7c0};  // last entry is unmapped
    int issued   = 0;  // csr instructions that owe an rd result
    int returned = 0;
    int timeouts = 0;

    csr_unit UUT (.*);

    bind csr_unit csr_unit_sva u_sva (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rstn && rd_valid_o) begin
            returned++;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    // one-cycle strobe, called 1 ns after a rising edge
    task automatic issue(input logic [31:0] instr, input logic [XLEN-1:0] data);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        rs1_data_i    = data;
        if (instr[6:0] == OPC_SYSTEM && instr[13:12] != 2'b00) begin
            issued++;
        end
        @(posedge clk);
        #1 instr_valid_i = 1'b0;
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [CSR_ADDR_W-1:0] addr,
                          input logic [4:0] rs1, input logic [XLEN-1:0] data);
        issue({addr, rs1, f3, 5'(issued + 1), OPC_SYSTEM}, data);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (returned != issued && n < 20) begin
            @(posedge clk);
            #1 n++;
        end
        if (returned != issued) begin
            timeouts++;
            $display("timeout at %0t: %0d rd results never arrived", $time, issued - returned);
        end
    endtask

    initial begin
        logic [2:0]            f3;
        logic [CSR_ADDR_W-1:0] addr;
        logic [4:0]            rs1;
        clk           = 1'b0;
        rstn          = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        idle(4);  // nothing issued, no rd result
        foreach (addr_tab[i]) begin
            csr_op(F3_CSRRS, addr_tab[i], 5'd0, 32'hffff_ffff);
        end
        csr_op(F3_CSRRW, CSR_MTVEC, 5'd1, 32'h0000_0100);
        csr_op(F3_CSRRW, CSR_MEPC, 5'd2, 32'h8000_0040);
        csr_op(F3_CSRRW, CSR_MSCRATCH, 5'd3, 32'h1234_5678);
        csr_op(F3_CSRRS, CSR_MSCRATCH, 5'd4, 32'h0f00_00f0);  // back to back, forwarded
        csr_op(F3_CSRRC, CSR_MSCRATCH, 5'd5, 32'h0000_0078);
        csr_op(F3_CSRRC, CSR_MSCRATCH, 5'd0, 32'hffff_ffff);
        csr_op(F3_CSRRWI, CSR_MIE, 5'd11, '0);
        csr_op(F3_CSRRSI, CSR_MSTATUS, 5'd8, '0);
        csr_op(F3_CSRRCI, CSR_MSTATUS, 5'd0, '0);
        csr_op(F3_CSRRCI, CSR_MSTATUS, 5'd8, '0);
        csr_op(F3_CSRRW, CSR_CYCLE, 5'd7, 32'hdead_beef);
        csr_op(F3_CSRRW, CSR_CYCLEH, 5'd7, 32'hdead_beef);
        csr_op(F3_CSRRW, 12'h7c0, 5'd7, 32'hdead_beef);
        issue(32'h0020_81b3, 32'h1);  // add, dropped at decode
        issue({12'h000, 5'd0, 3'b000, 5'd0, OPC_SYSTEM}, 32'h1);
        issue({CSR_MTVEC, 5'd1, 3'b100, 5'd3, OPC_SYSTEM}, 32'h1);
        csr_op(F3_CSRRS, CSR_CYCLE, 5'd0, '0);
        csr_op(F3_CSRRS, CSR_CYCLE, 5'd0, '0);
        idle(4);
        csr_op(F3_CSRRS, CSR_CYCLE, 5'd0, '0);
        wait_drain();
        for (int n = 0; n < 300; n++) begin
            f3   = 3'(take_bits(3));
            addr = addr_tab[take_bits(4) % 9];
            rs1  = (take_bits(2) == 0) ? 5'd0 : 5'(take_bits(5));
            issue({addr, rs1, f3, 5'(take_bits(5)), OPC_SYSTEM}, take_bits(32));
            idle(int'(take_bits(2) % 3));
        end
        wait_drain();
        $display("summary: %0d csr instructions, %0d rd results, %0d assertion failures, %0d timeouts",
                 issued, returned, UUT.u_sva.fail_cnt, timeouts);
        if (UUT.u_sva.fail_cnt == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
hw/isa_pkg.sv
hw/csr_pkg.sv
hw/csr_if.sv
hw/csr_decode.sv
hw/csr_alu.sv
hw/csr_reg.sv
hw/csr_unit.sv
testbench/csr_unit_sva.sv
testbench/csr_unit_tb.sv

//--- run.sh
#!/bin/sh
# builds the csr_unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module csr_unit_tb -Mdir obj_dir -f list.f

out=$(./obj_dir/Vcsr_unit_tb +verilator+error+limit+100000 || true)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"
